/* list.f */
rtl/dtim_pkg.sv
rtl/dtim_ram.sv
rtl/dtim_ctrl.sv
rtl/dtim.sv
verif/dtim_checker.sv
verif/dtim_tb.sv

/* rtl/dtim.sv */
`default_nettype none

module dtim (
  input  wire                  clock,
  input  wire                  reset,
  // processor side
  input  wire                  mem_valid,
  input  wire                  mem_fence,
  input  wire [31:0]           mem_addr,
  input  wire dtim_pkg::word_t mem_wdata,
  input  wire [3:0]            mem_wstrb,
  output dtim_pkg::word_t      mem_rdata,
  output logic                 mem_ready,
  // backing side
  output logic                 dmem_valid,
  output logic [31:0]          dmem_addr,
  output dtim_pkg::word_t      dmem_wdata,
  output logic [3:0]           dmem_wstrb,
  input  wire dtim_pkg::word_t dmem_rdata,
  input  wire                  dmem_ready
);

  import dtim_pkg::*;

  logic [index_bits-1:0] tag_raddr;
  tag_entry_t            tag_rdata;
  logic                  tag_wen;
  logic [index_bits-1:0] tag_waddr;
  tag_entry_t            tag_wdata;

  logic [index_bits-1:0] data_raddr;
  word_t                 data_rdata;
  logic                  data_wen;
  logic [index_bits-1:0] data_waddr;
  word_t                 data_wdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tag and word storage side by side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  dtim_ram #(
    .payload_t (tag_entry_t)
  ) tag_store (
    .clock (clock),
    .raddr (tag_raddr),
    .rdata (tag_rdata),
    .wen   (tag_wen),
    .waddr (tag_waddr),
    .wdata (tag_wdata)
  );

  dtim_ram #(
    .payload_t (word_t)
  ) data_store (
    .clock (clock),
    .raddr (data_raddr),
    .rdata (data_rdata),
    .wen   (data_wen),
    .waddr (data_waddr),
    .wdata (data_wdata)
  );

  dtim_ctrl ctrl (
    .clock      (clock),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_fence  (mem_fence),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .tag_raddr  (tag_raddr),
    .tag_rdata  (tag_rdata),
    .tag_wen    (tag_wen),
    .tag_waddr  (tag_waddr),
    .tag_wdata  (tag_wdata),
    .data_raddr (data_raddr),
    .data_rdata (data_rdata),
    .data_wen   (data_wen),
    .data_waddr (data_waddr),
    .data_wdata (data_wdata),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

endmodule

`default_nettype wire

/* rtl/dtim_ctrl.sv */
`default_nettype none

module dtim_ctrl (
  input  wire                             clock,
  input  wire                             reset,
  // processor side
  input  wire                             mem_valid,
  input  wire                             mem_fence,
  input  wire [31:0]                      mem_addr,
  input  wire dtim_pkg::word_t            mem_wdata,
  input  wire [3:0]                       mem_wstrb,
  output dtim_pkg::word_t                 mem_rdata,
  output logic                            mem_ready,
  // tag store
  output logic [dtim_pkg::index_bits-1:0] tag_raddr,
  input  wire dtim_pkg::tag_entry_t       tag_rdata,
  output logic                            tag_wen,
  output logic [dtim_pkg::index_bits-1:0] tag_waddr,
  output dtim_pkg::tag_entry_t            tag_wdata,
  // data store
  output logic [dtim_pkg::index_bits-1:0] data_raddr,
  input  wire dtim_pkg::word_t            data_rdata,
  output logic                            data_wen,
  output logic [dtim_pkg::index_bits-1:0] data_waddr,
  output dtim_pkg::word_t                 data_wdata,
  // backing side
  output logic                            dmem_valid,
  output logic [31:0]                     dmem_addr,
  output dtim_pkg::word_t                 dmem_wdata,
  output logic [3:0]                      dmem_wstrb,
  input  wire dtim_pkg::word_t            dmem_rdata,
  input  wire                             dmem_ready
);

  import dtim_pkg::*;

  typedef enum logic [1:0] {
    st_hit,
    st_miss,
    st_bypass,
    st_fence
  } state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // front register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic                  f_valid;
  logic                  f_fence;
  logic                  f_store;
  logic [31:0]           f_addr;
  logic [tag_bits-1:0]   f_tag;
  logic [index_bits-1:0] f_index;
  word_t                 f_data;
  logic [3:0]            f_strb;

  always_ff @(posedge clock) begin
    if (!reset) begin
      f_valid <= 1'b0;
    end else begin
      f_valid <= mem_valid;  // one cycle pulse
    end
  end

  // held for miss and bypass until the next request
  always_ff @(posedge clock) begin
    if (mem_valid) begin
      f_fence <= mem_fence;
      f_store <= |mem_wstrb;
      f_addr  <= {mem_addr[31:2], 2'b00};
      f_tag   <= mem_addr[31:index_bits+2];
      f_index <= mem_addr[index_bits+1:2];
      f_data  <= mem_wdata;
      f_strb  <= mem_wstrb;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // back machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  state_t                state_q;
  state_t                state_d;
  logic [index_bits-1:0] fence_idx_q;
  logic [index_bits-1:0] fence_idx_d;
  logic                  wb_pending_q;  // fence write-back in flight
  logic                  wb_pending_d;
  logic                  fence_read;
  logic                  in_window;
  logic                  tag_match;
  logic [index_bits-1:0] read_idx;

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, logic [3:0] strb);
    word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign in_window = (f_addr >= dtim_base_addr) && (f_addr < dtim_top_addr);
  assign tag_match = tag_rdata.lock && (tag_rdata.tag == f_tag);

  always_comb begin
    state_d      = state_q;
    fence_idx_d  = fence_idx_q;
    wb_pending_d = wb_pending_q;
    fence_read   = 1'b0;
    mem_ready    = 1'b0;
    mem_rdata    = '0;
    tag_wen      = 1'b0;
    tag_waddr    = f_index;
    tag_wdata    = '0;
    data_wen     = 1'b0;
    data_waddr   = f_index;
    data_wdata   = '0;
    dmem_valid   = 1'b0;
    dmem_addr    = f_addr;
    dmem_wdata   = '0;
    dmem_wstrb   = '0;

    case (state_q)
      st_hit: begin
        if (f_valid) begin
          if (f_fence) begin
            state_d      = st_fence;
            fence_idx_d  = '0;
            wb_pending_d = 1'b0;
            fence_read   = 1'b1;  // start the walk at entry zero
          end else if (!in_window || (tag_rdata.lock && !tag_match)) begin
            state_d    = st_bypass;
            dmem_valid = 1'b1;
            dmem_wdata = f_store ? f_data : '0;
            dmem_wstrb = f_strb;
          end else if (!tag_rdata.lock) begin
            state_d    = st_miss;
            dmem_valid = 1'b1;  // fetch now and merge store bytes later
          end else begin
            mem_ready = 1'b1;
            if (f_store) begin
              tag_wen         = 1'b1;
              tag_wdata.lock  = 1'b1;
              tag_wdata.dirty = 1'b1;
              tag_wdata.tag   = f_tag;
              data_wen        = 1'b1;
              data_wdata      = merge_bytes(data_rdata, f_data, f_strb);
            end else begin
              mem_rdata = data_rdata;
            end
          end
        end
      end

      st_miss: begin
        if (dmem_ready) begin
          state_d         = st_hit;
          mem_ready       = 1'b1;
          mem_rdata       = dmem_rdata;
          tag_wen         = 1'b1;
          tag_wdata.lock  = 1'b1;
          tag_wdata.dirty = f_store;
          tag_wdata.tag   = f_tag;
          data_wen        = 1'b1;
          data_wdata      = merge_bytes(dmem_rdata, f_data, f_strb);
        end
      end

      st_bypass: begin
        if (dmem_ready) begin
          state_d   = st_hit;
          mem_ready = 1'b1;
          mem_rdata = dmem_rdata;
        end
      end

      st_fence: begin
        fence_read = 1'b1;
        tag_waddr  = fence_idx_q;
        data_waddr = fence_idx_q;
        if (!wb_pending_q && tag_rdata.lock && tag_rdata.dirty) begin
          wb_pending_d = 1'b1;
          dmem_valid   = 1'b1;
          dmem_addr    = {tag_rdata.tag, fence_idx_q, 2'b00};
          dmem_wdata   = data_rdata;
          dmem_wstrb   = 4'hf;
        end else if (!wb_pending_q || dmem_ready) begin
          // clear the entry behind and step on
          wb_pending_d = 1'b0;
          tag_wen      = 1'b1;
          data_wen     = 1'b1;
          if (fence_idx_q == index_bits'(dtim_depth - 1)) begin
            state_d   = st_hit;
            mem_ready = 1'b1;
          end else begin
            fence_idx_d = fence_idx_q + 1'b1;
          end
        end
      end

      default: begin
        state_d = st_hit;
      end
    endcase
  end

  // stores answer on the next cycle
  assign read_idx   = fence_read ? fence_idx_d : mem_addr[index_bits+1:2];
  assign tag_raddr  = read_idx;
  assign data_raddr = read_idx;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q      <= st_hit;
      fence_idx_q  <= '0;
      wb_pending_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fence_idx_q  <= fence_idx_d;
      wb_pending_q <= wb_pending_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/dtim_pkg.sv */
`default_nettype none

package dtim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int dtim_depth = 64;                  // entries, one word each
  localparam int index_bits = $clog2(dtim_depth);
  localparam int tag_bits   = 30 - index_bits;     // above index and byte offset

  // cached window from base up to but not including top
  // four tags per index fit inside it
  localparam logic [31:0] dtim_base_addr = 32'h0000_1000;
  localparam logic [31:0] dtim_top_addr  = dtim_base_addr + 4 * dtim_depth * 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] word_t;

  typedef struct packed {
    logic                lock;   // entry holds a word
    logic                dirty;  // word differs from backing memory
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

endpackage

`default_nettype wire

/* rtl/dtim_ram.sv */
`default_nettype none

module dtim_ram #(
  parameter type payload_t = dtim_pkg::word_t
) (
  input  wire                             clock,
  input  wire [dtim_pkg::index_bits-1:0]  raddr,
  output payload_t                        rdata,
  input  wire                             wen,
  input  wire [dtim_pkg::index_bits-1:0]  waddr,
  input  wire payload_t                   wdata
);

  import dtim_pkg::*;

  payload_t ram [0:dtim_depth-1] = '{default: '0};

  logic [index_bits-1:0] raddr_q = '0;  // registered read address

  always_ff @(posedge clock) begin
    raddr_q <= raddr;
    if (wen) begin
      ram[waddr] <= wdata;
    end
  end

  // data follows the address by one cycle
  assign rdata = ram[raddr_q];

endmodule

`default_nettype wire

/* verif/dtim_checker.sv */
`default_nettype none

module dtim_checker #(
  parameter dtim_pkg::word_t init_xor = '0
) (
  input wire                  clock,
  input wire                  reset,
  input wire                  mem_valid,
  input wire                  mem_fence,
  input wire [31:0]           mem_addr,
  input wire dtim_pkg::word_t mem_wdata,
  input wire [3:0]            mem_wstrb,
  input wire dtim_pkg::word_t mem_rdata,
  input wire                  mem_ready,
  input wire                  dmem_valid,
  input wire [31:0]           dmem_addr,
  input wire dtim_pkg::word_t dmem_wdata,
  input wire [3:0]            dmem_wstrb
);

  timeunit 1ns;
  timeprecision 1ps;

  import dtim_pkg::*;

  typedef enum {k_hit, k_miss, k_bypass, k_fence} kind_t;

  word_t       shadow [logic [31:0]];   // processor view of stored words
  word_t       backing [logic [31:0]];  // built from observed dmem writes
  logic        locked [0:dtim_depth-1] = '{default: 1'b0};
  logic [31:0] locked_addr [0:dtim_depth-1];
  int          error_count = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  logic        pending = 1'b0;
  kind_t       kind;
  logic [31:0] req_addr;
  word_t       req_data;
  logic [3:0]  req_strb;
  word_t       exp_rdata;
  int          age;
  int          dmem_count;

  // expected load word from the shadow or the fill rule
  function automatic word_t expected_word(logic [31:0] a);
    return shadow.exists(a) ? shadow[a] : (a ^ init_xor);
  endfunction

  function automatic word_t backing_word(logic [31:0] a);
    return backing.exists(a) ? backing[a] : (a ^ init_xor);
  endfunction

  function automatic word_t merge(word_t old_word, word_t new_word, logic [3:0] strb);
    word_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  task automatic fail_value(input string name, input word_t exp, input word_t act);
    $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    error_count++;
    test_errors++;
  endtask

  task automatic fail_text(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %-16s done, %0d mismatches", tests_run, name, test_errors);
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("%0d tests run, %0d checks failed", tests_run, error_count);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watch both ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clock) begin : watch
    logic [index_bits-1:0] idx;
    if (reset) begin
      if (pending) age++;
      if (dmem_valid) begin
        if (!pending) begin
          fail_text("dmem_valid pulsed with no request outstanding");
        end else if (kind == k_fence) begin
          idx = dmem_addr[index_bits+1:2];
          if (!shadow.exists(dmem_addr) || !locked[idx] || locked_addr[idx] != dmem_addr)
            fail_text($sformatf("write-back of clean or uncached address %h", dmem_addr));
          if (dmem_wstrb != 4'hf) fail_value("dmem_wstrb", 32'hf, 32'(dmem_wstrb));
          if (dmem_wdata != expected_word(dmem_addr))
            fail_value("dmem_wdata", expected_word(dmem_addr), dmem_wdata);
        end else begin
          dmem_count++;
          if (dmem_addr != req_addr) fail_value("dmem_addr", req_addr, dmem_addr);
          if (dmem_wstrb != ((kind == k_bypass) ? req_strb : 4'h0))
            fail_value("dmem_wstrb", (kind == k_bypass) ? 32'(req_strb) : 0, 32'(dmem_wstrb));
          if (kind == k_bypass && |req_strb && dmem_wdata != req_data)
            fail_value("dmem_wdata", req_data, dmem_wdata);
        end
        if (|dmem_wstrb)
          backing[dmem_addr] = merge(backing_word(dmem_addr), dmem_wdata, dmem_wstrb);
      end
      if (mem_ready) begin
        if (!pending) begin
          fail_text("mem_ready pulsed with no request outstanding");
        end else begin
          if (kind == k_hit && age != 1) fail_value("mem_ready latency", 32'd1, 32'(age));
          if (kind == k_hit && dmem_count != 0)
            fail_text($sformatf("hit made %0d dmem accesses", dmem_count));
          if ((kind == k_miss || kind == k_bypass) && dmem_count != 1)
            fail_text($sformatf("expected one dmem access, saw %0d", dmem_count));
          if (kind != k_fence && req_strb == 4'h0 && mem_rdata != exp_rdata)
            fail_value("mem_rdata", exp_rdata, mem_rdata);
          if (kind == k_hit && req_strb != 4'h0 && mem_rdata != '0)
            fail_value("mem_rdata", '0, mem_rdata);
          if (kind == k_fence) begin
            if (age < dtim_depth)
              fail_text($sformatf("fence ended after only %0d cycles", age));
            foreach (shadow[a]) begin
              if (backing_word(a) != shadow[a])
                fail_value("backing image", shadow[a], backing_word(a));
            end
            for (int i = 0; i < dtim_depth; i++) locked[i] = 1'b0;  // store cleared
          end
          pending = 1'b0;
        end
      end
      if (mem_valid) begin
        if (pending) fail_text("request issued while another was outstanding");
        pending    = 1'b1;
        age        = 0;
        dmem_count = 0;
        req_addr   = {mem_addr[31:2], 2'b00};
        req_data   = mem_wdata;
        req_strb   = mem_fence ? 4'h0 : mem_wstrb;
        idx        = mem_addr[index_bits+1:2];
        exp_rdata  = expected_word(req_addr);
        if (mem_fence) begin
          kind = k_fence;
        end else if (req_addr < dtim_base_addr || req_addr >= dtim_top_addr) begin
          kind = k_bypass;
        end else if (locked[idx] && locked_addr[idx] == req_addr) begin
          kind = k_hit;
        end else if (locked[idx]) begin
          kind = k_bypass;  // other tag holds the entry
        end else begin
          kind             = k_miss;
          locked[idx]      = 1'b1;
          locked_addr[idx] = req_addr;
        end
        if (|req_strb) shadow[req_addr] = merge(exp_rdata, mem_wdata, mem_wstrb);
      end
    end
  end

endmodule

`default_nettype wire

/* verif/dtim_tb.sv */
`default_nettype none

module dtim_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dtim_pkg::*;

  localparam int          clock_period   = 40;
  localparam logic [31:0] lfsr_seed      = 32'd68994;
  localparam word_t       init_xor       = 32'h5a5a_c3c3;  // backing memory fill
  localparam int          random_ops     = 40;
  localparam int          total_requests = 2 + 2 * random_ops + 15 + 2;
  localparam longint      timeout_ns     =
    longint'(total_requests) * dtim_depth * 8 * clock_period + 200 * clock_period;

  logic        clock = 1'b0;
  logic        reset = 1'b0;
  logic        mem_valid = 1'b0;
  logic        mem_fence = 1'b0;
  logic [31:0] mem_addr = '0;
  word_t       mem_wdata = '0;
  logic [3:0]  mem_wstrb = '0;
  word_t       mem_rdata;
  logic        mem_ready;
  logic        dmem_valid;
  logic [31:0] dmem_addr;
  word_t       dmem_wdata;
  logic [3:0]  dmem_wstrb;
  word_t       dmem_rdata = '0;
  logic        dmem_ready = 1'b0;

  logic [31:0] stim_lfsr = lfsr_seed;
  logic [31:0] mem_lfsr = lfsr_seed;  // separate generator for memory latency

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  initial begin
    forever #(clock_period / 2) clock = ~clock;
  end

  dtim dtim_i (.*);

  dtim_checker #(.init_xor(init_xor)) checker_i (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // backing memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  word_t       backing_mem [logic [31:0]];
  logic        mem_busy = 1'b0;
  int          mem_wait = 0;
  logic [31:0] mem_req_addr;
  word_t       mem_req_wdata;
  logic [3:0]  mem_req_strb;

  always @(posedge clock) begin : backing_model
    logic [31:0] lat;
    word_t       cur;
    dmem_ready <= 1'b0;
    if (!reset) begin
      mem_busy <= 1'b0;
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        cur = backing_mem.exists(mem_req_addr) ? backing_mem[mem_req_addr]
                                               : mem_req_addr ^ init_xor;
        for (int b = 0; b < 4; b++) begin
          if (mem_req_strb[b]) cur[8*b +: 8] = mem_req_wdata[8*b +: 8];
        end
        backing_mem[mem_req_addr] = cur;
        dmem_rdata <= cur;
        dmem_ready <= 1'b1;
        mem_busy   <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (dmem_valid) begin
      draw_bits(mem_lfsr, 2, lat);  // 1 to 4 cycles
      mem_req_addr  <= dmem_addr;
      mem_req_wdata <= dmem_wdata;
      mem_req_strb  <= dmem_wstrb;
      mem_wait      <= int'(lat);
      mem_busy      <= 1'b1;
    end
  end

  task automatic access(input logic [31:0] addr, input word_t data, input logic [3:0] strb,
                        input logic fence);
    @(posedge clock);
    mem_valid <= 1'b1;
    mem_fence <= fence;
    mem_addr  <= addr;
    mem_wdata <= data;
    mem_wstrb <= strb;
    @(posedge clock);
    mem_valid <= 1'b0;
    mem_fence <= 1'b0;
    do @(posedge clock); while (!mem_ready);
    @(negedge clock);  // checker has seen the response by now
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequences
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [31:0] idx;
    logic [31:0] strb;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] conflict;
    repeat (16) @(posedge clock);
    reset <= 1'b1;

    repeat (8) @(negedge clock);
    checker_i.end_test("reset idle");

    access(dtim_base_addr + 32'h40, '0, 4'h0, 1'b0);  // miss
    access(dtim_base_addr + 32'h40, '0, 4'h0, 1'b0);  // hit
    checker_i.end_test("load miss hit");

    for (int i = 0; i < random_ops; i++) begin
      draw_bits(stim_lfsr, 8, idx);
      draw_bits(stim_lfsr, 4, strb);
      draw_bits(stim_lfsr, 32, data);
      addr = dtim_base_addr + {idx[29:0], 2'b00};
      access(addr, data, strb[3:0], 1'b0);
      access(addr, '0, 4'h0, 1'b0);
    end
    checker_i.end_test("random window");

    for (int i = 0; i < 6; i++) begin
      draw_bits(stim_lfsr, 10, idx);
      draw_bits(stim_lfsr, 32, data);
      addr = {idx[29:0], 2'b00};  // below the window
      access(addr, data, 4'hf, 1'b0);
      access(addr, '0, 4'h0, 1'b0);
    end
    conflict = dtim_base_addr + 32'h40 + dtim_depth * 4;  // same index under another tag
    access(conflict, 32'hc0de_0042, 4'h3, 1'b0);
    access(conflict, '0, 4'h0, 1'b0);
    access(conflict, '0, 4'h0, 1'b0);
    checker_i.end_test("bypass");

    access('0, '0, 4'h0, 1'b1);
    checker_i.end_test("fence");

    access(dtim_base_addr + 32'h40, '0, 4'h0, 1'b0);
    checker_i.end_test("reload");

    checker_i.report_counts();
    if (checker_i.error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("watchdog expired, the DUT stopped answering requests");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
